//--- include/mshr_config.svh
//****************************************************************************
// MSHR block sizing. Set counts and way count must be powers of two.
// Widths are derived from these values in mshr_pkg.
//****************************************************************************
`ifndef MSHR_CONFIG_SVH
`define MSHR_CONFIG_SVH

// Number of sets in the data cache
`define MSHR_CACHE_SETS 64

// Number of MSHR sets
// Low cache-set bits select the MSHR set
`define MSHR_SETS 4

// Ways per MSHR set, i.e. misses in flight per MSHR set
`define MSHR_WAYS 2

// Line tag carried with each miss
`define MSHR_TAG_WIDTH 20

// Requester id returned with the response
`define MSHR_ID_WIDTH 4

`endif

//--- sim.f
+incdir+include
source/mshr_pkg.sv
source/mshr_alloc_ctrl.sv
source/mshr_directory.sv
source/mshr_to_cache_set.sv
source/mshr_refill_resp.sv
source/mshr_top.sv
test/mshr_chk.sv
test/mshr_tb.sv

//--- source/mshr_alloc_ctrl.sv
//****************************************************************************
// Miss intake. A miss to a full MSHR set is refused, never queued.
// Request and reject pulses come one cycle after alloc_i.
//****************************************************************************
`timescale 1ns/1ps
`default_nettype none

`include "mshr_config.svh"

module mshr_alloc_ctrl (
    input  wire logic                  clk_i,
    input  wire logic                  rst_n_i,

    // Miss from the cache
    input  wire logic                  alloc_i,
    input  wire mshr_pkg::line_tag_t   alloc_tag_i,
    input  wire mshr_pkg::cache_set_t  alloc_set_i,
    input  wire mshr_pkg::req_id_t     alloc_id_i,
    output logic                       alloc_full_o,

    // Occupancy of the addressed MSHR set
    input  wire logic [`MSHR_WAYS-1:0] set_valid_i,

    // Entry write
    output logic                       dir_write_o,
    output mshr_pkg::mshr_set_t        dir_write_set_o,
    output mshr_pkg::mshr_way_t        dir_write_way_o,

    // Memory request and refusal
    output logic                       mem_req_o,
    output mshr_pkg::mshr_id_t         mem_req_id_o,
    output mshr_pkg::line_tag_t        mem_req_tag_o,
    output mshr_pkg::cache_set_t       mem_req_set_o,
    output logic                       alloc_reject_o
);
    import mshr_pkg::*;

    mshr_set_t mshr_set;
    mshr_way_t free_way;
    logic      accept;

    // Low cache-set bits pick the MSHR set
    assign mshr_set = mshr_set_t'(alloc_set_i);

    // Full when no way is left
    assign alloc_full_o = &set_valid_i;

    // Lowest free way wins
    // Scanning downward lets the lowest index overwrite
    always_comb begin
        free_way = '0;
        for (int w = `MSHR_WAYS - 1; w >= 0; w--) begin
            if (!set_valid_i[w]) begin
                free_way = mshr_way_t'(w);
            end
        end
    end

    assign accept = alloc_i & ~alloc_full_o;

    // Entry written at the same edge as the request register
    assign dir_write_o     = accept;
    assign dir_write_set_o = mshr_set;
    assign dir_write_way_o = free_way;

    // Pulse flags
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mem_req_o      <= 1'b0;
            alloc_reject_o <= 1'b0;
        end else begin
            mem_req_o      <= accept;
            alloc_reject_o <= alloc_i & alloc_full_o;
        end
    end

    // Request payload, loaded only for an accepted miss
    always_ff @(posedge clk_i) begin
        if (accept) begin
            mem_req_id_o  <= {mshr_set, free_way};
            mem_req_tag_o <= alloc_tag_i;
            mem_req_set_o <= alloc_set_i;
        end
    end

endmodule

`default_nettype wire

//--- source/mshr_directory.sv
//****************************************************************************
// MSHR entry storage. Write and free to one entry in the same cycle
// is not expected; the caller keeps them apart.
//****************************************************************************
`timescale 1ns/1ps
`default_nettype none

`include "mshr_config.svh"

module mshr_directory (
    input  wire logic                  clk_i,
    input  wire logic                  rst_n_i,

    // Allocation write
    input  wire logic                  write_i,
    input  wire mshr_pkg::mshr_set_t   write_set_i,
    input  wire mshr_pkg::mshr_way_t   write_way_i,
    input  wire mshr_pkg::line_tag_t   write_tag_i,
    input  wire mshr_pkg::req_id_t     write_id_i,

    // Per-set occupancy for the allocator
    input  wire mshr_pkg::mshr_set_t   lookup_set_i,
    output logic [`MSHR_WAYS-1:0]      lookup_valid_o,

    // Single-entry read for refill
    input  wire mshr_pkg::mshr_set_t   read_set_i,
    input  wire mshr_pkg::mshr_way_t   read_way_i,
    output logic                       read_valid_o,
    output mshr_pkg::line_tag_t        read_tag_o,
    output mshr_pkg::req_id_t          read_id_o,

    // Release on refill
    input  wire logic                  free_i,
    input  wire mshr_pkg::mshr_set_t   free_set_i,
    input  wire mshr_pkg::mshr_way_t   free_way_i
);
    import mshr_pkg::*;

    // Valid bits, packed per set for the lookup port
    logic [`MSHR_SETS-1:0][`MSHR_WAYS-1:0] valid_q;

    // Payload arrays
    line_tag_t tag_q [`MSHR_SETS][`MSHR_WAYS];
    req_id_t   id_q  [`MSHR_SETS][`MSHR_WAYS];

    // Valid update
    // Write and free hit different entries, so order does not matter
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= '0;
        end else begin
            if (write_i) begin
                valid_q[write_set_i][write_way_i] <= 1'b1;
            end
            if (free_i) begin
                valid_q[free_set_i][free_way_i] <= 1'b0;
            end
        end
    end

    // Tag and requester id of the new entry
    always_ff @(posedge clk_i) begin
        if (write_i) begin
            tag_q[write_set_i][write_way_i] <= write_tag_i;
            id_q[write_set_i][write_way_i]  <= write_id_i;
        end
    end

    // Combinational reads
    assign lookup_valid_o = valid_q[lookup_set_i];

    assign read_valid_o = valid_q[read_set_i][read_way_i];
    assign read_tag_o   = tag_q[read_set_i][read_way_i];
    assign read_id_o    = id_q[read_set_i][read_way_i];

endmodule

`default_nettype wire

//--- source/mshr_pkg.sv
//****************************************************************************
// Shared MSHR types. Single-entry dimensions keep a width of at least 1.
//****************************************************************************
`default_nettype none

`include "mshr_config.svh"

package mshr_pkg;

    // Index widths from the config values
    localparam int CACHE_SET_WIDTH = ($clog2(`MSHR_CACHE_SETS) > 0) ?
                                     $clog2(`MSHR_CACHE_SETS) : 1;
    localparam int MSHR_SET_WIDTH  = ($clog2(`MSHR_SETS) > 0) ? $clog2(`MSHR_SETS) : 1;
    localparam int MSHR_WAY_WIDTH  = ($clog2(`MSHR_WAYS) > 0) ? $clog2(`MSHR_WAYS) : 1;

    // Packed set and way, as sent to memory
    localparam int MSHR_IDX_WIDTH  = MSHR_SET_WIDTH + MSHR_WAY_WIDTH;

    localparam int TAG_WIDTH       = `MSHR_TAG_WIDTH;
    localparam int REQ_ID_WIDTH    = `MSHR_ID_WIDTH;

    // High cache-set bits dropped by the MSHR set index
    localparam int TRLT_WIDTH      = (CACHE_SET_WIDTH > MSHR_SET_WIDTH) ?
                                     (CACHE_SET_WIDTH - MSHR_SET_WIDTH) : 1;

    typedef logic [CACHE_SET_WIDTH-1:0] cache_set_t;
    typedef logic [MSHR_SET_WIDTH-1:0]  mshr_set_t;
    typedef logic [MSHR_WAY_WIDTH-1:0]  mshr_way_t;

    // {set, way}, set in the upper bits
    typedef logic [MSHR_IDX_WIDTH-1:0]  mshr_id_t;

    typedef logic [TAG_WIDTH-1:0]       line_tag_t;
    typedef logic [REQ_ID_WIDTH-1:0]    req_id_t;

    // One translation table entry
    typedef logic [TRLT_WIDTH-1:0]      trlt_entry_t;

endpackage

`default_nettype wire

//--- source/mshr_refill_resp.sv
//****************************************************************************
// Refill handling. A refill of an invalid entry is dropped silently.
// Response one cycle after refill_i; the entry frees at that edge.
//****************************************************************************
`timescale 1ns/1ps
`default_nettype none

module mshr_refill_resp (
    input  wire logic                  clk_i,
    input  wire logic                  rst_n_i,

    // Refill strobe from memory
    input  wire logic                  refill_i,
    input  wire mshr_pkg::mshr_id_t    refill_id_i,

    // Entry lookup
    output mshr_pkg::mshr_set_t        read_set_o,
    output mshr_pkg::mshr_way_t        read_way_o,
    input  wire logic                  entry_valid_i,
    input  wire mshr_pkg::line_tag_t   entry_tag_i,
    input  wire mshr_pkg::req_id_t     entry_id_i,
    input  wire mshr_pkg::cache_set_t  entry_cache_set_i,

    // Entry release
    output logic                       free_o,
    output mshr_pkg::mshr_set_t        free_set_o,
    output mshr_pkg::mshr_way_t        free_way_o,

    // Response to the cache
    output logic                       resp_valid_o,
    output mshr_pkg::cache_set_t       resp_set_o,
    output mshr_pkg::line_tag_t        resp_tag_o,
    output mshr_pkg::req_id_t          resp_id_o
);
    import mshr_pkg::*;

    logic hit;

    // Id layout is {set, way}
    assign read_set_o = refill_id_i[MSHR_WAY_WIDTH +: MSHR_SET_WIDTH];
    assign read_way_o = refill_id_i[0 +: MSHR_WAY_WIDTH];

    // Only a pending entry answers
    assign hit = refill_i & entry_valid_i;

    // Free the same entry that was read
    assign free_o     = hit;
    assign free_set_o = read_set_o;
    assign free_way_o = read_way_o;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            resp_valid_o <= 1'b0;
        end else begin
            resp_valid_o <= hit;
        end
    end

    // Response fields captured with the free
    always_ff @(posedge clk_i) begin
        if (hit) begin
            resp_set_o <= entry_cache_set_i;
            resp_tag_o <= entry_tag_i;
            resp_id_o  <= entry_id_i;
        end
    end

endmodule

`default_nettype wire

//--- source/mshr_to_cache_set.sv
//****************************************************************************
// Cache-set recovery from an MSHR set and way. Table has no reset and
// is only meaningful behind a valid entry.
//****************************************************************************
`timescale 1ns/1ps
`default_nettype none

`include "mshr_config.svh"

module mshr_to_cache_set (
    input  wire logic                  clk_i,

    // Write on allocation
    input  wire logic                  write_i,
    input  wire mshr_pkg::cache_set_t  write_cache_set_i,
    input  wire mshr_pkg::mshr_way_t   write_way_i,

    // Read on refill
    input  wire mshr_pkg::mshr_way_t   read_way_i,
    input  wire mshr_pkg::mshr_set_t   read_set_i,
    output mshr_pkg::cache_set_t       read_cache_set_o
);
    import mshr_pkg::*;

    if (`MSHR_CACHE_SETS > `MSHR_SETS) begin : gen_table
        // High cache-set bits per MSHR set and way
        trlt_entry_t tab_q [`MSHR_SETS][`MSHR_WAYS];
        trlt_entry_t tab_wdata;
        mshr_set_t   write_set;

        // Write address from the low bits, data from the high bits
        assign write_set = mshr_set_t'(write_cache_set_i);
        assign tab_wdata = write_cache_set_i[MSHR_SET_WIDTH +: TRLT_WIDTH];

        always_ff @(posedge clk_i) begin
            if (write_i) begin
                tab_q[write_set][write_way_i] <= tab_wdata;
            end
        end

        // Stored high bits above the MSHR set
        assign read_cache_set_o = {tab_q[read_set_i][read_way_i], read_set_i};
    end else begin : gen_no_table
        // MSHR set already holds the whole cache set
        assign read_cache_set_o = cache_set_t'(read_set_i);
    end

endmodule

`default_nettype wire

//--- source/mshr_top.sv
//****************************************************************************
// MSHR block top. Miss to request and refill to response take one cycle.
// No flow control toward memory; full sets refuse misses.
//****************************************************************************
`timescale 1ns/1ps
`default_nettype none

`include "mshr_config.svh"

module mshr_top (
    input  wire logic                  clk_i,
    input  wire logic                  rst_n_i,

    // Miss
    input  wire logic                  alloc_i,
    input  wire mshr_pkg::line_tag_t   alloc_tag_i,
    input  wire mshr_pkg::cache_set_t  alloc_set_i,
    input  wire mshr_pkg::req_id_t     alloc_id_i,
    output logic                       alloc_full_o,
    output logic                       alloc_reject_o,

    // Memory request
    output logic                       mem_req_o,
    output mshr_pkg::mshr_id_t         mem_req_id_o,
    output mshr_pkg::line_tag_t        mem_req_tag_o,
    output mshr_pkg::cache_set_t       mem_req_set_o,

    // Refill
    input  wire logic                  refill_i,
    input  wire mshr_pkg::mshr_id_t    refill_id_i,

    // Response
    output logic                       resp_valid_o,
    output mshr_pkg::cache_set_t       resp_set_o,
    output mshr_pkg::line_tag_t        resp_tag_o,
    output mshr_pkg::req_id_t          resp_id_o
);
    import mshr_pkg::*;

    // Allocation path
    logic                  dir_write;
    mshr_set_t             dir_write_set;
    mshr_way_t             dir_write_way;
    logic [`MSHR_WAYS-1:0] set_valid;

    // Refill path
    mshr_set_t             rd_set;
    mshr_way_t             rd_way;
    logic                  entry_valid;
    line_tag_t             entry_tag;
    req_id_t               entry_id;
    cache_set_t            entry_cache_set;
    logic                  dir_free;
    mshr_set_t             free_set;
    mshr_way_t             free_way;

    mshr_alloc_ctrl u_alloc_ctrl (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .alloc_i         (alloc_i),
        .alloc_tag_i     (alloc_tag_i),
        .alloc_set_i     (alloc_set_i),
        .alloc_id_i      (alloc_id_i),
        .alloc_full_o    (alloc_full_o),
        .set_valid_i     (set_valid),
        .dir_write_o     (dir_write),
        .dir_write_set_o (dir_write_set),
        .dir_write_way_o (dir_write_way),
        .mem_req_o       (mem_req_o),
        .mem_req_id_o    (mem_req_id_o),
        .mem_req_tag_o   (mem_req_tag_o),
        .mem_req_set_o   (mem_req_set_o),
        .alloc_reject_o  (alloc_reject_o)
    );

    // Lookup set equals the set being written
    mshr_directory u_directory (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .write_i        (dir_write),
        .write_set_i    (dir_write_set),
        .write_way_i    (dir_write_way),
        .write_tag_i    (alloc_tag_i),
        .write_id_i     (alloc_id_i),
        .lookup_set_i   (dir_write_set),
        .lookup_valid_o (set_valid),
        .read_set_i     (rd_set),
        .read_way_i     (rd_way),
        .read_valid_o   (entry_valid),
        .read_tag_o     (entry_tag),
        .read_id_o      (entry_id),
        .free_i         (dir_free),
        .free_set_i     (free_set),
        .free_way_i     (free_way)
    );

    mshr_to_cache_set u_to_cache_set (
        .clk_i             (clk_i),
        .write_i           (dir_write),
        .write_cache_set_i (alloc_set_i),
        .write_way_i       (dir_write_way),
        .read_way_i        (rd_way),
        .read_set_i        (rd_set),
        .read_cache_set_o  (entry_cache_set)
    );

    mshr_refill_resp u_refill_resp (
        .clk_i             (clk_i),
        .rst_n_i           (rst_n_i),
        .refill_i          (refill_i),
        .refill_id_i       (refill_id_i),
        .read_set_o        (rd_set),
        .read_way_o        (rd_way),
        .entry_valid_i     (entry_valid),
        .entry_tag_i       (entry_tag),
        .entry_id_i        (entry_id),
        .entry_cache_set_i (entry_cache_set),
        .free_o            (dir_free),
        .free_set_o        (free_set),
        .free_way_o        (free_way),
        .resp_valid_o      (resp_valid_o),
        .resp_set_o        (resp_set_o),
        .resp_tag_o        (resp_tag_o),
        .resp_id_o         (resp_id_o)
    );

endmodule

`default_nettype wire

//--- test/mshr_chk.sv
//****************************************************************************
// Protocol assertions for mshr_top, bound in from the testbench side.
// Pulses may repeat only when a new strobe arrived at the same edge.
//****************************************************************************
`timescale 1ns/1ps
`default_nettype none

module mshr_chk (
    input  wire logic               clk_i,
    input  wire logic               rst_n_i,
    input  wire logic               alloc_i,
    input  wire logic               refill_i,
    input  wire mshr_pkg::mshr_id_t refill_id_i,
    input  wire logic               mem_req_o,
    input  wire mshr_pkg::mshr_id_t mem_req_id_o,
    input  wire logic               alloc_reject_o,
    input  wire logic               resp_valid_o
);
    import mshr_pkg::*;

    localparam int NUM_IDS = 1 << MSHR_IDX_WIDTH;

    // Pending entries as seen from the ports
    logic [NUM_IDS-1:0] pend_q;
    logic [NUM_IDS-1:0] pend_now;
    logic               refill_hit;

    // Count of assertion failures
    int fail_count = 0;

    // A request shows an entry that is already valid
    always_comb begin
        pend_now = pend_q;
        if (mem_req_o) begin
            pend_now[mem_req_id_o] = 1'b1;
        end
    end

    assign refill_hit = refill_i && pend_now[refill_id_i];

    // Refill of a pending entry frees it at the next edge
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pend_q <= '0;
        end else begin
            pend_q <= pend_now;
            if (refill_hit) begin
                pend_q[refill_id_i] <= 1'b0;
            end
        end
    end

    // A miss is either accepted or refused, never both
    a_req_reject_excl: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(mem_req_o && alloc_reject_o))
        else begin
            fail_count++;
            $error("mem_req_o and alloc_reject_o high together");
        end

    // Refill of a pending entry answers one cycle later
    a_resp_after_hit: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        refill_hit |=> resp_valid_o)
        else begin
            fail_count++;
            $error("valid refill gave no response");
        end

    // No response without a valid refill before it
    a_resp_only_hit: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        resp_valid_o |-> $past(refill_hit))
        else begin
            fail_count++;
            $error("response without a valid refill");
        end

    // Pulses last one cycle unless re-triggered
    a_req_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (mem_req_o && !alloc_i) |=> !mem_req_o)
        else begin
            fail_count++;
            $error("mem_req_o held for two cycles");
        end

    a_reject_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (alloc_reject_o && !alloc_i) |=> !alloc_reject_o)
        else begin
            fail_count++;
            $error("alloc_reject_o held for two cycles");
        end

    a_resp_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (resp_valid_o && !refill_i) |=> !resp_valid_o)
        else begin
            fail_count++;
            $error("resp_valid_o held for two cycles");
        end

endmodule

bind mshr_top mshr_chk u_chk (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .alloc_i        (alloc_i),
    .refill_i       (refill_i),
    .refill_id_i    (refill_id_i),
    .mem_req_o      (mem_req_o),
    .mem_req_id_o   (mem_req_id_o),
    .alloc_reject_o (alloc_reject_o),
    .resp_valid_o   (resp_valid_o)
);

`default_nettype wire

//--- test/mshr_tb.sv
//****************************************************************************
// Directed MSHR testbench with an occupancy model. One operation at a time,
// two cycles apart; a miss and a refill may share one cycle.
//****************************************************************************
`timescale 1ns/1ps
`default_nettype none

`include "mshr_config.svh"

module mshr_tb;
    import mshr_pkg::*;

    localparam int WAIT_LIMIT = 8;
    // Distinct high parts of a cache set
    localparam int HI_SETS = (`MSHR_CACHE_SETS > `MSHR_SETS) ?
                             (`MSHR_CACHE_SETS / `MSHR_SETS) : 1;

    logic       clk_i;
    logic       rst_n_i;
    logic       alloc_i;
    line_tag_t  alloc_tag_i;
    cache_set_t alloc_set_i;
    req_id_t    alloc_id_i;
    logic       refill_i;
    mshr_id_t   refill_id_i;
    logic       alloc_full_o;
    logic       alloc_reject_o;
    logic       mem_req_o;
    mshr_id_t   mem_req_id_o;
    line_tag_t  mem_req_tag_o;
    cache_set_t mem_req_set_o;
    logic       resp_valid_o;
    cache_set_t resp_set_o;
    line_tag_t  resp_tag_o;
    req_id_t    resp_id_o;

    // Occupancy model per MSHR set and way
    bit         m_valid [`MSHR_SETS][`MSHR_WAYS];
    line_tag_t  m_tag   [`MSHR_SETS][`MSHR_WAYS];
    cache_set_t m_cs    [`MSHR_SETS][`MSHR_WAYS];
    req_id_t    m_rid   [`MSHR_SETS][`MSHR_WAYS];

    string test_name;
    int    test_errors;
    int    errors;
    int    checks;
    int    tests_run;
    int    tests_failed;
    int    seed = 32'h7dc53355;

    mshr_top UUT (.*);

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    task automatic compare(input string what, input logic [63:0] exp, input logic [63:0] act);
        checks++;
        if (exp !== act) begin
            test_errors++;
            errors++;
            $display("** Error %s: %s expected %0h, actual %0h", test_name, what, exp, act);
        end
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = 0;
        tests_run++;
    endtask

    task automatic finish_test();
        if (test_errors != 0) begin
            tests_failed++;
            $display("%s: FAILED, %0d errors", test_name, test_errors);
        end else begin
            $display("%s: ok", test_name);
        end
    endtask

    // One miss and/or refill, checked against the model
    task automatic issue(input bit do_alloc, input line_tag_t tag, input cache_set_t cs,
                         input req_id_t rid, input bit do_refill, input mshr_id_t fid);
        int ms;
        int way;
        int rs;
        int rw;
        int cycles;
        bit full;
        bit exp_req;
        bit exp_rej;
        bit exp_resp;
        ms   = cs % `MSHR_SETS;
        rs   = fid / `MSHR_WAYS;
        rw   = fid % `MSHR_WAYS;
        full = 1'b1;
        way  = 0;
        // Lowest free way
        for (int w = `MSHR_WAYS - 1; w >= 0; w--) begin
            if (!m_valid[ms][w]) begin
                full = 1'b0;
                way  = w;
            end
        end
        exp_req  = do_alloc && !full;
        exp_rej  = do_alloc && full;
        exp_resp = do_refill && m_valid[rs][rw];
        @(posedge clk_i);
        alloc_i     <= do_alloc;
        alloc_tag_i <= tag;
        alloc_set_i <= cs;
        alloc_id_i  <= rid;
        refill_i    <= do_refill;
        refill_id_i <= fid;
        @(negedge clk_i);
        compare("alloc_full_o", full, alloc_full_o);
        @(posedge clk_i);
        alloc_i  <= 1'b0;
        refill_i <= 1'b0;
        cycles = 0;
        if (exp_req || exp_rej || exp_resp) begin
            do begin
                @(negedge clk_i);
                cycles++;
            end while (!(mem_req_o || alloc_reject_o || resp_valid_o) && cycles < WAIT_LIMIT);
            if (!(mem_req_o || alloc_reject_o || resp_valid_o)) begin
                test_errors++;
                errors++;
                $display("Timeout in %s: no output pulse within %0d cycles",
                         test_name, WAIT_LIMIT);
            end else begin
                compare("latency", 1, cycles);
            end
        end else begin
            @(negedge clk_i);
        end
        compare("mem_req_o", exp_req, mem_req_o);
        compare("alloc_reject_o", exp_rej, alloc_reject_o);
        compare("resp_valid_o", exp_resp, resp_valid_o);
        if (exp_req && mem_req_o) begin
            compare("mem_req_id_o", ms * `MSHR_WAYS + way, mem_req_id_o);
            compare("mem_req_tag_o", tag, mem_req_tag_o);
            compare("mem_req_set_o", cs, mem_req_set_o);
        end
        if (exp_resp && resp_valid_o) begin
            compare("resp_set_o", m_cs[rs][rw], resp_set_o);
            compare("resp_tag_o", m_tag[rs][rw], resp_tag_o);
            compare("resp_id_o", m_rid[rs][rw], resp_id_o);
        end
        // Model update after the edge
        if (exp_resp) begin
            m_valid[rs][rw] = 1'b0;
        end
        if (exp_req) begin
            m_valid[ms][way] = 1'b1;
            m_tag[ms][way]   = tag;
            m_cs[ms][way]    = cs;
            m_rid[ms][way]   = rid;
        end
    endtask

    task automatic miss(input cache_set_t cs);
        issue(1'b1, line_tag_t'($random(seed)), cs, req_id_t'($random(seed)), 1'b0, '0);
    endtask

    task automatic refill(input int s, input int w);
        issue(1'b0, '0, '0, '0, 1'b1, mshr_id_t'(s * `MSHR_WAYS + w));
    endtask

    // Refill every pending entry
    task automatic drain_entries();
        for (int s = 0; s < `MSHR_SETS; s++) begin
            for (int w = 0; w < `MSHR_WAYS; w++) begin
                if (m_valid[s][w]) begin
                    refill(s, w);
                end
            end
        end
    endtask

    task automatic check_full(input cache_set_t cs, input bit exp);
        @(posedge clk_i);
        alloc_set_i <= cs;
        @(negedge clk_i);
        compare("alloc_full_o", exp, alloc_full_o);
    endtask

    task automatic test_reset();
        start_test("reset");
        @(negedge clk_i);
        compare("mem_req_o", 0, mem_req_o);
        compare("alloc_reject_o", 0, alloc_reject_o);
        compare("resp_valid_o", 0, resp_valid_o);
        for (int s = 0; s < `MSHR_SETS; s++) begin
            check_full(cache_set_t'(s), 1'b0);
        end
        finish_test();
    endtask

    task automatic test_single_miss();
        start_test("single_miss");
        miss(cache_set_t'(`MSHR_SETS + 1));
        compare("way", 1 * `MSHR_WAYS, mem_req_id_o);
        refill(1, 0);
        finish_test();
    endtask

    // Same low bits, different high bits
    task automatic test_fill_set();
        start_test("fill_set");
        for (int k = 0; k < `MSHR_WAYS; k++) begin
            miss(cache_set_t'(((k * 5 + 1) % HI_SETS) * `MSHR_SETS + 2));
            compare("way", 2 * `MSHR_WAYS + k, mem_req_id_o);
        end
        check_full(cache_set_t'(2), 1'b1);
        miss(cache_set_t'(2));
        for (int w = `MSHR_WAYS - 1; w >= 0; w--) begin
            refill(2, w);
        end
        finish_test();
    endtask

    task automatic test_reuse_way();
        start_test("reuse_way");
        for (int k = 0; k < `MSHR_WAYS; k++) begin
            miss(cache_set_t'((k % HI_SETS) * `MSHR_SETS + 3));
        end
        refill(3, 0);
        miss(cache_set_t'(3));
        compare("reused way", 3 * `MSHR_WAYS, mem_req_id_o);
        miss(cache_set_t'(`MSHR_SETS));
        compare("other set", 0, mem_req_id_o);
        drain_entries();
        finish_test();
    endtask

    task automatic test_stray_refill();
        start_test("stray_refill");
        miss(cache_set_t'(2 * `MSHR_SETS + 1));
        refill(0, `MSHR_WAYS - 1);
        drain_entries();
        finish_test();
    endtask

    // Random misses and refills, some in the same cycle
    task automatic test_random();
        bit do_alloc;
        bit do_refill;
        start_test("random_mix");
        for (int i = 0; i < 200; i++) begin
            do_alloc  = ($unsigned($random(seed)) % 4) != 0;
            do_refill = ($unsigned($random(seed)) % 2) != 0;
            issue(do_alloc, line_tag_t'($random(seed)), cache_set_t'($random(seed)),
                  req_id_t'($random(seed)), do_refill, mshr_id_t'($random(seed)));
        end
        drain_entries();
        finish_test();
    endtask

    initial begin
        rst_n_i     = 1'b0;
        alloc_i     = 1'b0;
        alloc_tag_i = '0;
        alloc_set_i = '0;
        alloc_id_i  = '0;
        refill_i    = 1'b0;
        refill_id_i = '0;
        repeat (3) @(posedge clk_i);
        rst_n_i <= 1'b1;
        test_reset();
        test_single_miss();
        test_fill_set();
        test_reuse_way();
        test_stray_refill();
        test_random();
        // Assertion failures of the bound checker
        if (UUT.u_chk.fail_count != 0) begin
            errors += UUT.u_chk.fail_count;
            $display("Checker assertions failed %0d times", UUT.u_chk.fail_count);
        end
        $display("Tests run %0d, failing %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
